//--- logic/ptw_pkg.sv
// Sv39 IOMMU page table walker shared widths, PTE layout, cause codes and types
package ptw_pkg;

    // Sv39 address geometry
    localparam int unsigned VLEN        = 39;
    localparam int unsigned PLEN        = 56;
    localparam int unsigned PPNW        = 44;
    localparam int unsigned VPNW        = 27;
    localparam int unsigned PAGE_OFFSET = 12;
    // Each level indexes its table with 9 VPN bits
    localparam int unsigned VPN_SLICE_W = 9;
    // PTEs are 8 bytes wide
    localparam int unsigned PTE_SHIFT   = 3;
    localparam int unsigned PTE_WIDTH   = 64;

    // Tag and cause widths
    localparam int unsigned PSCID_WIDTH = 20;
    localparam int unsigned CAUSE_LEN   = 12;

    // PTE field positions
    localparam int unsigned PTE_V   = 0;
    localparam int unsigned PTE_R   = 1;
    localparam int unsigned PTE_W   = 2;
    localparam int unsigned PTE_X   = 3;
    localparam int unsigned PTE_U   = 4;
    localparam int unsigned PTE_G   = 5;
    localparam int unsigned PTE_A   = 6;
    localparam int unsigned PTE_D   = 7;
    localparam int unsigned PPN_LSB = 10;
    // Bits 63:54 reserved as Svnapot and Svpbmt are not supported
    localparam int unsigned RSV_LSB = 54;

    typedef logic [VLEN-1:0]        iova_t;
    typedef logic [PLEN-1:0]        paddr_t;
    typedef logic [PPNW-1:0]        ppn_t;
    typedef logic [VPNW-1:0]        vpn_t;
    typedef logic [PSCID_WIDTH-1:0] pscid_t;
    typedef logic [CAUSE_LEN-1:0]   cause_t;
    typedef logic [PTE_WIDTH-1:0]   pte_t;

    // Fault cause codes reported to the IOMMU
    localparam cause_t CAUSE_LOAD_PAGE_FAULT    = 12'd13;
    localparam cause_t CAUSE_STORE_PAGE_FAULT   = 12'd15;
    localparam cause_t CAUSE_PT_DATA_CORRUPTION = 12'd269;

    // Read data response code for a good beat
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Walk level where LVL1 holds the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    // Walker FSM states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } walk_state_e;

endpackage

//--- logic/pte_checker.sv
// Sv39 PTE classifier giving leaf or pointer and flagging page faults per level
`timescale 1ns/1ns

module pte_checker (
    input  ptw_pkg::pte_t   pte_i,
    input  ptw_pkg::level_e level_i,
    input  logic            is_store_i,
    output logic            pte_leaf_o,
    output logic            pte_fault_o
);
    import ptw_pkg::*;

    ppn_t ppn;
    logic invalid;
    logic reserved_set;
    logic misaligned;
    logic ptr_fault;
    logic leaf_fault;

    assign ppn = pte_i[PPN_LSB +: PPNW];

    // Readable or executable means leaf
    assign pte_leaf_o = pte_i[PTE_R] | pte_i[PTE_X];

    // Not valid, or write without read
    assign invalid = !pte_i[PTE_V] || (!pte_i[PTE_R] && pte_i[PTE_W]);

    assign reserved_set = |pte_i[PTE_WIDTH-1:RSV_LSB];

    // Superpage PPN must be aligned to the page size
    always_comb begin
        case (level_i)
            LVL1:    misaligned = |ppn[2*VPN_SLICE_W-1:0];
            LVL2:    misaligned = |ppn[VPN_SLICE_W-1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // A, D and U are reserved on pointers; no pointer allowed at the last level
    assign ptr_fault = !pte_leaf_o &&
                       (pte_i[PTE_A] || pte_i[PTE_D] || pte_i[PTE_U] || (level_i == LVL3));

    // Leaf needs A and R, and D for stores
    assign leaf_fault = pte_leaf_o &&
                        (misaligned || !pte_i[PTE_A] || !pte_i[PTE_R] ||
                         (is_store_i && !pte_i[PTE_D]));

    assign pte_fault_o = invalid || reserved_set || ptr_fault || leaf_fault;

endmodule

//--- logic/iotlb_fill.sv
// IOTLB fill path holding walk tags and sticky global bit for the update entry
`timescale 1ns/1ns

module iotlb_fill (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            walk_start_i,
    input  logic            pte_accept_i,
    input  ptw_pkg::iova_t  req_iova_i,
    input  ptw_pkg::pscid_t pscid_i,
    input  ptw_pkg::pte_t   mem_r_data_i,
    input  ptw_pkg::level_e level_i,
    output logic            up_is_2m_o,
    output logic            up_is_1g_o,
    output ptw_pkg::vpn_t   up_vpn_o,
    output ptw_pkg::pscid_t up_pscid_o,
    output ptw_pkg::pte_t   up_content_o
);
    import ptw_pkg::*;

    vpn_t   vpn_q;
    pscid_t pscid_q;
    // Set once any PTE on the walk path is global
    logic   global_q;
    pte_t   g_mask;

    // Tags captured as the walk starts
    always_ff @(posedge clk_i) begin
        if (walk_start_i) begin
            vpn_q   <= req_iova_i[VLEN-1:PAGE_OFFSET];
            pscid_q <= pscid_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (walk_start_i) begin
            global_q <= 1'b0;
        end else if (pte_accept_i && mem_r_data_i[PTE_G]) begin
            global_q <= 1'b1;
        end
    end

    // Leaf level sets the page size
    assign up_is_1g_o = (level_i == LVL1);
    assign up_is_2m_o = (level_i == LVL2);

    assign up_vpn_o   = vpn_q;
    assign up_pscid_o = pscid_q;

    // G inherited from pointer PTEs while the leaf's own G passes through
    assign g_mask       = pte_t'(global_q) << PTE_G;
    assign up_content_o = mem_r_data_i | g_mask;

endmodule

//--- logic/ptw_walk_ctrl.sv
// Sv39 walk FSM with level tracking, PTE pointer generation and error causes
`timescale 1ns/1ns

module ptw_walk_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              iotlb_access_i,
    input  logic              iotlb_hit_i,
    input  logic              is_store_i,
    input  ptw_pkg::iova_t    req_iova_i,
    input  ptw_pkg::ppn_t     iosatp_ppn_i,
    input  logic              mem_ar_ready_i,
    input  logic              mem_r_valid_i,
    input  ptw_pkg::pte_t     mem_r_data_i,
    input  logic [1:0]        mem_r_resp_i,
    input  logic              pte_leaf_i,
    input  logic              pte_fault_i,
    output logic              mem_ar_valid_o,
    output logic              mem_r_ready_o,
    output ptw_pkg::paddr_t   mem_ar_addr_o,
    output logic              ptw_active_o,
    output logic              ptw_error_o,
    output ptw_pkg::cause_t   cause_code_o,
    output logic              update_o,
    output logic              walk_start_o,
    output logic              pte_accept_o,
    output ptw_pkg::level_e   level_o
);
    import ptw_pkg::*;

    walk_state_e state_q, state_n;
    level_e      level_q, level_n;
    cause_t      cause_q, cause_n;
    // Request IOVA kept for the lower level indices
    iova_t       iova_q, iova_n;
    // Address of the PTE being fetched
    paddr_t      pptr_q, pptr_n;

    logic r_fire;
    logic bus_err;
    ppn_t pte_ppn;

    // VPN index of the given level
    function automatic logic [VPN_SLICE_W-1:0] vpn_slice(iova_t iova, level_e lvl);
        logic [VPN_SLICE_W-1:0] slice;
        case (lvl)
            LVL1:    slice = iova[PAGE_OFFSET + 2*VPN_SLICE_W +: VPN_SLICE_W];
            LVL2:    slice = iova[PAGE_OFFSET + VPN_SLICE_W +: VPN_SLICE_W];
            default: slice = iova[PAGE_OFFSET +: VPN_SLICE_W];
        endcase
        return slice;
    endfunction

    // Table base plus scaled index gives the PTE address
    function automatic paddr_t make_pptr(ppn_t ppn, logic [VPN_SLICE_W-1:0] idx);
        return {ppn, idx, {PTE_SHIFT{1'b0}}};
    endfunction

    // Miss seen only while idle
    assign walk_start_o = (state_q == IDLE) && iotlb_access_i && !iotlb_hit_i;

    // Read data is taken the cycle it shows up
    assign r_fire        = (state_q == PTE_LOOKUP) && mem_r_valid_i;
    assign mem_r_ready_o = r_fire;
    assign bus_err       = (mem_r_resp_i != RESP_OKAY);
    // Good beats feed the sticky global bit
    assign pte_accept_o  = r_fire && !bus_err;

    assign pte_ppn = mem_r_data_i[PPN_LSB +: PPNW];

    assign mem_ar_valid_o = (state_q == WAIT_GRANT);
    assign mem_ar_addr_o  = pptr_q;
    assign ptw_active_o   = (state_q != IDLE);
    assign ptw_error_o    = (state_q == PROPAGATE_ERROR);
    // Cause only shown during the error cycle
    assign cause_code_o   = (state_q == PROPAGATE_ERROR) ? cause_q : '0;
    assign level_o        = level_q;

    always_comb begin
        state_n  = state_q;
        level_n  = level_q;
        cause_n  = cause_q;
        iova_n   = iova_q;
        pptr_n   = pptr_q;
        update_o = 1'b0;

        case (state_q)
            IDLE: begin
                // Start at the root table named by iosatp
                if (walk_start_o) begin
                    state_n = WAIT_GRANT;
                    level_n = LVL1;
                    iova_n  = req_iova_i;
                    pptr_n  = make_pptr(iosatp_ppn_i, vpn_slice(req_iova_i, LVL1));
                end
            end

            WAIT_GRANT: begin
                // Address held stable until accepted
                if (mem_ar_ready_i) begin
                    state_n = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (r_fire) begin
                    if (bus_err) begin
                        // Bus error wins over any PTE check
                        cause_n = CAUSE_PT_DATA_CORRUPTION;
                        state_n = PROPAGATE_ERROR;
                    end else if (pte_fault_i) begin
                        cause_n = is_store_i ? CAUSE_STORE_PAGE_FAULT : CAUSE_LOAD_PAGE_FAULT;
                        state_n = PROPAGATE_ERROR;
                    end else if (pte_leaf_i) begin
                        // Translation found
                        update_o = 1'b1;
                        state_n  = IDLE;
                    end else begin
                        // Pointer PTE, descend one level
                        // A pointer at LVL3 is flagged as a fault by the checker
                        level_n = (level_q == LVL1) ? LVL2 : LVL3;
                        pptr_n  = make_pptr(pte_ppn, vpn_slice(iova_q, level_n));
                        state_n = WAIT_GRANT;
                    end
                end
            end

            // PROPAGATE_ERROR lasts a single cycle
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= LVL1;
            cause_q <= '0;
        end else begin
            state_q <= state_n;
            level_q <= level_n;
            cause_q <= cause_n;
        end
    end

    always_ff @(posedge clk_i) begin
        iova_q <= iova_n;
        pptr_q <= pptr_n;
    end

endmodule

//--- logic/ptw_top.sv
// Sv39 page table walker top joining walk FSM, PTE checks and IOTLB fill
`timescale 1ns/1ns

module ptw_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    // IOTLB miss monitor and request info
    input  logic              iotlb_access_i,
    input  logic              iotlb_hit_i,
    input  logic              is_store_i,
    input  ptw_pkg::iova_t    req_iova_i,
    input  ptw_pkg::pscid_t   pscid_i,
    input  ptw_pkg::ppn_t     iosatp_ppn_i,
    // Memory read channels
    input  logic              mem_ar_ready_i,
    input  logic              mem_r_valid_i,
    input  ptw_pkg::pte_t     mem_r_data_i,
    input  logic [1:0]        mem_r_resp_i,
    output logic              mem_ar_valid_o,
    output logic              mem_r_ready_o,
    output ptw_pkg::paddr_t   mem_ar_addr_o,
    // Status and error report
    output logic              ptw_active_o,
    output logic              ptw_error_o,
    output ptw_pkg::cause_t   cause_code_o,
    // IOTLB update
    output logic              update_o,
    output logic              up_is_2m_o,
    output logic              up_is_1g_o,
    output ptw_pkg::vpn_t     up_vpn_o,
    output ptw_pkg::pscid_t   up_pscid_o,
    output ptw_pkg::pte_t     up_content_o
);
    import ptw_pkg::*;

    // Walk progress towards the fill logic
    logic   walk_start;
    logic   pte_accept;
    level_e level;

    // Classification of the fetched PTE
    logic pte_leaf;
    logic pte_fault;

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .iotlb_access_i (iotlb_access_i),
        .iotlb_hit_i    (iotlb_hit_i),
        .is_store_i     (is_store_i),
        .req_iova_i     (req_iova_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_resp_i   (mem_r_resp_i),
        .pte_leaf_i     (pte_leaf),
        .pte_fault_i    (pte_fault),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .update_o       (update_o),
        .walk_start_o   (walk_start),
        .pte_accept_o   (pte_accept),
        .level_o        (level)
    );

    pte_checker u_pte_checker (
        .pte_i       (mem_r_data_i),
        .level_i     (level),
        .is_store_i  (is_store_i),
        .pte_leaf_o  (pte_leaf),
        .pte_fault_o (pte_fault)
    );

    iotlb_fill u_iotlb_fill (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_start_i (walk_start),
        .pte_accept_i (pte_accept),
        .req_iova_i   (req_iova_i),
        .pscid_i      (pscid_i),
        .mem_r_data_i (mem_r_data_i),
        .level_i      (level),
        .up_is_2m_o   (up_is_2m_o),
        .up_is_1g_o   (up_is_1g_o),
        .up_vpn_o     (up_vpn_o),
        .up_pscid_o   (up_pscid_o),
        .up_content_o (up_content_o)
    );

endmodule

//--- tests/tb_ptw.sv
// Testbench for the Sv39 page table walker driving walks from a case table against a memory model
`timescale 1ns/1ns

module tb_ptw;
    import ptw_pkg::*;

    // One walk with its page-table words and expected outcome
    typedef struct packed {
        iova_t      iova;
        pscid_t     pscid;
        ppn_t       root;
        logic       is_store;
        pte_t [2:0] pte;
        logic [2:0] berr;
        logic [1:0] last;
        // Zero cause means an update is expected
        cause_t     cause;
        // Page size as {1G, 2M}
        logic [1:0] size;
    } walk_case_t;

    localparam ppn_t   P1   = 44'h100;
    localparam ppn_t   P2   = 44'h200;
    localparam ppn_t   LP   = 44'h12345;
    localparam pte_t   NONE = 64'd0;
    localparam cause_t NOC  = 12'd0;
    localparam cause_t LPF  = 12'd13;
    localparam cause_t SPF  = 12'd15;
    localparam cause_t BUS  = 12'd269;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic iotlb_access_i, iotlb_hit_i, is_store_i;
    iova_t req_iova_i;
    pscid_t pscid_i;
    ppn_t iosatp_ppn_i;
    logic mem_ar_ready_i, mem_r_valid_i;
    pte_t mem_r_data_i;
    logic [1:0] mem_r_resp_i;
    logic mem_ar_valid_o, mem_r_ready_o;
    paddr_t mem_ar_addr_o;
    logic ptw_active_o, ptw_error_o;
    cause_t cause_code_o;
    logic update_o, up_is_2m_o, up_is_1g_o;
    vpn_t up_vpn_o;
    pscid_t up_pscid_o;
    pte_t up_content_o;

    walk_case_t cases[$];
    logic [31:0] lfsr;

    ptw_top DUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .iotlb_access_i (iotlb_access_i),
        .iotlb_hit_i    (iotlb_hit_i),
        .is_store_i     (is_store_i),
        .req_iova_i     (req_iova_i),
        .pscid_i        (pscid_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_resp_i   (mem_r_resp_i),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_r_ready_o  (mem_r_ready_o),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .update_o       (update_o),
        .up_is_2m_o     (up_is_2m_o),
        .up_is_1g_o     (up_is_1g_o),
        .up_vpn_o       (up_vpn_o),
        .up_pscid_o     (up_pscid_o),
        .up_content_o   (up_content_o)
    );

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic watchdog(int unsigned rows);
        #(rows * 40 * 40);
        $display("Timeout: the walker did not finish the case table in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Handshake delay of 0 to 3 cycles with one LFSR step per bit
    task automatic take_delay(logic use_delay, output logic [1:0] d);
        d = 2'd0;
        if (use_delay) begin
            repeat (2) begin
                lfsr = lfsr_step(lfsr);
                d = {d[0], lfsr[0]};
            end
        end
    endtask

    function automatic pte_t ptr_pte(ppn_t ppn);
        return {10'd0, ppn, 2'd0, 8'h01};
    endfunction

    function automatic pte_t leaf_pte(ppn_t ppn, logic [7:0] flags);
        return {10'd0, ppn, 2'd0, flags};
    endfunction

    // Table base shifted by 12 plus the level's VPN index shifted by 3
    function automatic paddr_t expect_addr(ppn_t base, iova_t iova, logic [1:0] lvl);
        logic [8:0] idx;
        case (lvl)
            2'd0:    idx = iova[38:30];
            2'd1:    idx = iova[29:21];
            default: idx = iova[20:12];
        endcase
        return (paddr_t'(base) << 12) | (paddr_t'(idx) << 3);
    endfunction

    task automatic add_case(logic st, pte_t p0, pte_t p1, pte_t p2, logic [2:0] berr,
                            logic [1:0] last, cause_t cause, logic [1:0] size);
        walk_case_t c;
        int unsigned n;
        n = cases.size();
        // Every row moves all three VPN slices by one
        c.iova     = 39'h41_2345_6789 + iova_t'(n) * 39'h4020_1000;
        c.pscid    = pscid_t'(n) + 20'h10000;
        c.root     = ppn_t'(n) + 44'h80000;
        c.is_store = st;
        c.pte      = {p2, p1, p0};
        c.berr     = berr;
        c.last     = last;
        c.cause    = cause;
        c.size     = size;
        cases.push_back(c);
    endtask

    task automatic build_table();
        // Successful 4K, 1G, 2M walks and G inherited from a pointer
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2), leaf_pte(LP, 8'hc7), 3'b000, 2'd2, NOC, 2'b00);
        add_case(1'b0, leaf_pte(44'h40000, 8'h43), NONE, NONE, 3'b000, 2'd0, NOC, 2'b10);
        add_case(1'b1, ptr_pte(P1), leaf_pte(44'h400, 8'hc7), NONE, 3'b000, 2'd1, NOC, 2'b01);
        add_case(1'b0, ptr_pte(P1) | 64'h20, ptr_pte(P2), leaf_pte(LP, 8'hc3), 3'b000, 2'd2,
                 NOC, 2'b00);
        // Invalid, write without read, reserved bits
        add_case(1'b0, NONE, NONE, NONE, 3'b000, 2'd0, LPF, 2'b00);
        add_case(1'b1, ptr_pte(P1), leaf_pte(LP, 8'h05), NONE, 3'b000, 2'd1, SPF, 2'b00);
        add_case(1'b0, ptr_pte(P1) | (64'd1 << 60), NONE, NONE, 3'b000, 2'd0, LPF, 2'b00);
        // A, D, U on pointers and a pointer at the last level
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2) | 64'h40, NONE, 3'b000, 2'd1, LPF, 2'b00);
        add_case(1'b1, ptr_pte(P1) | 64'h80, NONE, NONE, 3'b000, 2'd0, SPF, 2'b00);
        add_case(1'b0, ptr_pte(P1) | 64'h10, NONE, NONE, 3'b000, 2'd0, LPF, 2'b00);
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2), ptr_pte(LP), 3'b000, 2'd2, LPF, 2'b00);
        // Misaligned superpages
        add_case(1'b0, leaf_pte(44'h40001, 8'h43), NONE, NONE, 3'b000, 2'd0, LPF, 2'b00);
        add_case(1'b1, ptr_pte(P1), leaf_pte(44'h401, 8'hc7), NONE, 3'b000, 2'd1, SPF, 2'b00);
        // Leaf without A, execute only, store without D
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2), leaf_pte(LP, 8'h03), 3'b000, 2'd2, LPF, 2'b00);
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2), leaf_pte(LP, 8'h49), 3'b000, 2'd2, LPF, 2'b00);
        add_case(1'b1, ptr_pte(P1), ptr_pte(P2), leaf_pte(LP, 8'h47), 3'b000, 2'd2, SPF, 2'b00);
        // Bus errors at each level
        add_case(1'b0, ptr_pte(P1), NONE, NONE, 3'b001, 2'd0, BUS, 2'b00);
        add_case(1'b1, ptr_pte(P1), ptr_pte(P2), NONE, 3'b010, 2'd1, BUS, 2'b00);
        add_case(1'b0, ptr_pte(P1), ptr_pte(P2), leaf_pte(LP, 8'hc7), 3'b100, 2'd2, BUS, 2'b00);
    endtask

    task automatic run_case(walk_case_t c, logic use_delay);
        ppn_t       base;
        logic       g_seen;
        logic [1:0] lvl;
        logic [1:0] d;
        paddr_t     addr;
        pte_t       exp_content;
        base   = c.root;
        g_seen = 1'b0;
        @(negedge clk_i);
        iotlb_access_i = 1'b1;
        req_iova_i     = c.iova;
        pscid_i        = c.pscid;
        iosatp_ppn_i   = c.root;
        is_store_i     = c.is_store;
        @(negedge clk_i);
        iotlb_access_i = 1'b0;
        for (lvl = 2'd0; lvl <= c.last; lvl++) begin
            // Address phase where ar_valid must be up and hold its address
            addr = expect_addr(base, c.iova, lvl);
            take_delay(use_delay, d);
            #10;
            check_value("ptw_active_o", 64'(ptw_active_o), 64'd1);
            check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd1);
            check_value("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(addr));
            repeat (d) begin
                @(negedge clk_i);
                #10;
                check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd1);
                check_value("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(addr));
            end
            @(negedge clk_i);
            mem_ar_ready_i = 1'b1;
            @(negedge clk_i);
            mem_ar_ready_i = 1'b0;
            take_delay(use_delay, d);
            repeat (d) @(negedge clk_i);
            // Data beat for this level
            mem_r_valid_i = 1'b1;
            mem_r_data_i  = c.pte[lvl];
            mem_r_resp_i  = c.berr[lvl] ? 2'b10 : 2'b00;
            g_seen        = g_seen | c.pte[lvl][PTE_G];
            #10;
            check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'd1);
            check_value("ptw_error_o", 64'(ptw_error_o), 64'd0);
            if (lvl == c.last && c.cause == NOC) begin
                exp_content = c.pte[lvl];
                if (g_seen) begin
                    exp_content[PTE_G] = 1'b1;
                end
                check_value("update_o", 64'(update_o), 64'd1);
                check_value("up_is_1g_o", 64'(up_is_1g_o), 64'(c.size[1]));
                check_value("up_is_2m_o", 64'(up_is_2m_o), 64'(c.size[0]));
                check_value("up_vpn_o", 64'(up_vpn_o), 64'(c.iova[38:12]));
                check_value("up_pscid_o", 64'(up_pscid_o), 64'(c.pscid));
                check_value("up_content_o", up_content_o, exp_content);
            end else begin
                check_value("update_o", 64'(update_o), 64'd0);
            end
            @(negedge clk_i);
            mem_r_valid_i = 1'b0;
            base = c.pte[lvl][PPN_LSB +: PPNW];
        end
        #10;
        if (c.cause != NOC) begin
            // Single error cycle with the cause
            check_value("ptw_error_o", 64'(ptw_error_o), 64'd1);
            check_value("cause_code_o", 64'(cause_code_o), 64'(c.cause));
            check_value("update_o", 64'(update_o), 64'd0);
            @(negedge clk_i);
            #10;
        end
        check_value("ptw_active_o", 64'(ptw_active_o), 64'd0);
        check_value("ptw_error_o", 64'(ptw_error_o), 64'd0);
        check_value("update_o", 64'(update_o), 64'd0);
        check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
    endtask

    initial begin
        rst_ni         = 1'b0;
        iotlb_access_i = 1'b0;
        iotlb_hit_i    = 1'b0;
        is_store_i     = 1'b0;
        req_iova_i     = '0;
        pscid_i        = '0;
        iosatp_ppn_i   = '0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_resp_i   = 2'b00;
        lfsr           = 32'hf39d02e9;
        build_table();
        // Two passes over the table plus reset
        fork
            watchdog(2 * cases.size() + 1);
        join_none
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        #10;
        check_value("ptw_active_o", 64'(ptw_active_o), 64'd0);
        check_value("update_o", 64'(update_o), 64'd0);
        check_value("ptw_error_o", 64'(ptw_error_o), 64'd0);
        check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
        check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'd0);
        check_value("cause_code_o", 64'(cause_code_o), 64'd0);
        // IOTLB hit must not start a walk
        @(negedge clk_i);
        iotlb_access_i = 1'b1;
        iotlb_hit_i    = 1'b1;
        @(negedge clk_i);
        iotlb_access_i = 1'b0;
        iotlb_hit_i    = 1'b0;
        #10;
        check_value("ptw_active_o", 64'(ptw_active_o), 64'd0);
        check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
        // First pass without back-pressure and a second with random delays
        for (int pass = 0; pass < 2; pass++) begin
            foreach (cases[i]) begin
                run_case(cases[i], pass == 1);
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- list.f
logic/ptw_pkg.sv
logic/pte_checker.sv
logic/iotlb_fill.sv
logic/ptw_walk_ctrl.sv
logic/ptw_top.sv
tests/tb_ptw.sv

//--- run.sh
#!/bin/sh
# Build and run the Sv39 page table walker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns -f list.f --top-module tb_ptw -o tb_ptw
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ptw > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
